/* tetris_pkg.sv */
package tetris_pkg;

  //////////////////////////////////////////////////
  // Board geometry
  //////////////////////////////////////////////////

  // Default board size, the top level may override
  localparam int COLS_DEF = 10;
  localparam int ROWS_DEF = 22;

  //////////////////////////////////////////////////
  // Cell and row types
  //////////////////////////////////////////////////

  // Zero is an empty cell
  typedef logic [2:0] color_t;

  // One board row, cell 0 is the leftmost column
  typedef color_t [COLS_DEF-1:0] row_t;

  // Three cells in row 1, extra cell in row 0 except BAR
  typedef enum logic [1:0] {
    TEE, // extra over middle
    ELL, // extra over left
    JAY, // extra over right
    BAR  // flat, no extra
  } piece_t;

  //////////////////////////////////////////////////
  // Pipeline words
  //////////////////////////////////////////////////

  // Spawn request from the game
  typedef struct packed {
    piece_t piece;
    color_t color;
  } spawn_req_t;

  // Scan stage to placer stage
  typedef struct packed {
    spawn_req_t req;
    logic       found;
    logic [3:0] col_index;
  } scan_t;

  // Result back to the game
  typedef struct packed {
    logic       ok;
    logic [4:0] row_ref;
    logic [3:0] col_ref;
  } spawn_res_t;

endpackage

/* spawn_intake.sv */
`timescale 1ns/1ps

module spawn_intake (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_in,
  input  tetris_pkg::spawn_req_t spawn_req,
  input  logic                   buf_space,
  output logic                   ack_in,
  output logic                   intake_valid,
  output tetris_pkg::spawn_req_t intake_req
);

  // Four-phase receiver states
  typedef enum logic {
    S_IDLE, // ack low, waiting for req
    S_ACK   // ack high, waiting for req to drop
  } state_t;

  state_t state;
  logic   capture;

  // Take a request only when idle and a result slot is free
  // Idle state implies ack_in is low
  assign capture = (state == S_IDLE) && req_in && buf_space;

  //////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= S_IDLE;
      intake_valid <= 1'b0;
    end else begin
      // One pulse per captured request
      intake_valid <= capture;
      case (state)
        S_IDLE: begin
          if (capture) begin
            state <= S_ACK;
          end
        end
        S_ACK: begin
          // Requester released, return to idle
          if (!req_in) begin
            state <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Request word, loaded only on capture
  always_ff @(posedge clk) begin
    if (capture) begin
      intake_req <= spawn_req;
    end
  end

  // Ack follows the state register
  assign ack_in = (state == S_ACK);

endmodule

/* slot_scan.sv */
`timescale 1ns/1ps

module slot_scan #(
  parameter int COLS = tetris_pkg::COLS_DEF,
  parameter int ROWS = tetris_pkg::ROWS_DEF
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   intake_valid,
  input  tetris_pkg::spawn_req_t intake_req,
  input  tetris_pkg::row_t       row0,
  input  tetris_pkg::row_t       row1,
  output logic                   scan_valid,
  output tetris_pkg::scan_t      scan_data
);

  // Board size must fit the row type and the reference fields
  if (COLS < 3 || COLS > tetris_pkg::COLS_DEF || ROWS < 2 || ROWS > 32) begin : g_size_check
    $error("slot_scan: unsupported board size");
  end

  logic       hit;
  logic [3:0] hit_col;
  logic       base_free;
  logic       extra_free;

  //////////////////////////////////////////////////
  // Free place search
  //////////////////////////////////////////////////

  // Walk from the right so the last hit is the leftmost one
  always_comb begin
    hit        = 1'b0;
    hit_col    = '0;
    base_free  = 1'b0;
    extra_free = 1'b0;
    for (int i = COLS - 3; i >= 0; i--) begin
      // Three cells in row 1
      base_free = (row1[i] == '0) && (row1[i+1] == '0) && (row1[i+2] == '0);
      // Extra cell in row 0 depends on the kind
      case (intake_req.piece)
        tetris_pkg::TEE: extra_free = (row0[i+1] == '0);
        tetris_pkg::ELL: extra_free = (row0[i] == '0);
        tetris_pkg::JAY: extra_free = (row0[i+2] == '0);
        default:         extra_free = 1'b1;
      endcase
      if (base_free && extra_free) begin
        hit     = 1'b1;
        hit_col = 4'(i);
      end
    end
  end

  //////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      scan_valid <= 1'b0;
    end else begin
      scan_valid <= intake_valid;
    end
  end

  // Payload carries the request along with the search result
  always_ff @(posedge clk) begin
    if (intake_valid) begin
      scan_data.req       <= intake_req;
      scan_data.found     <= hit;
      scan_data.col_index <= hit_col;
    end
  end

endmodule

/* block_placer.sv */
`timescale 1ns/1ps

module block_placer #(
  parameter int COLS = tetris_pkg::COLS_DEF,
  parameter int ROWS = tetris_pkg::ROWS_DEF
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   scan_valid,
  input  tetris_pkg::scan_t      scan_data,
  input  tetris_pkg::row_t       row0,
  input  tetris_pkg::row_t       row1,
  output logic                   place_en,
  output tetris_pkg::row_t       place_row0,
  output tetris_pkg::row_t       place_row1,
  output logic                   place_valid,
  output tetris_pkg::spawn_res_t place_res
);

  int                    base_col;
  int                    extra_col;
  logic                  has_extra;
  tetris_pkg::color_t    paint;
  tetris_pkg::spawn_res_t res_next;

  //////////////////////////////////////////////////
  // Painting
  //////////////////////////////////////////////////

  assign paint = scan_data.req.color;

  // Row-0 cell position by kind
  always_comb begin
    base_col  = int'(scan_data.col_index);
    has_extra = 1'b1;
    extra_col = base_col;
    case (scan_data.req.piece)
      tetris_pkg::TEE: extra_col = base_col + 1;
      tetris_pkg::ELL: extra_col = base_col;
      tetris_pkg::JAY: extra_col = base_col + 2;
      default:         has_extra = 1'b0;
    endcase
  end

  // Copies of the rows with the piece drawn in
  always_comb begin
    place_row0 = row0;
    place_row1 = row1;
    for (int j = 0; j < COLS; j++) begin
      if (j >= base_col && j <= base_col + 2) begin
        place_row1[j] = paint;
      end
      if (has_extra && j == extra_col) begin
        place_row0[j] = paint;
      end
    end
  end

  // Store write lands on the same edge as the stage register
  assign place_en = scan_valid && scan_data.found;

  //////////////////////////////////////////////////
  // Result word
  //////////////////////////////////////////////////

  always_comb begin
    res_next = '0;
    if (scan_data.found) begin
      res_next.ok      = 1'b1;
      res_next.row_ref = 5'(ROWS - 1);
      // Column left of the piece, wraps to the last column
      if (scan_data.col_index == '0) begin
        res_next.col_ref = 4'(COLS - 1);
      end else begin
        res_next.col_ref = scan_data.col_index - 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      place_valid <= 1'b0;
    end else begin
      place_valid <= scan_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (scan_valid) begin
      place_res <= res_next;
    end
  end

endmodule

/* top_rows_store.sv */
`timescale 1ns/1ps

module top_rows_store #(
  parameter int COLS = tetris_pkg::COLS_DEF
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             place_en,
  input  tetris_pkg::row_t place_row0,
  input  tetris_pkg::row_t place_row1,
  input  logic             load_en,
  input  logic             load_sel,
  input  tetris_pkg::row_t load_row,
  output tetris_pkg::row_t row0,
  output tetris_pkg::row_t row1
);

  tetris_pkg::row_t load_masked;

  // Cells past the board edge always stay empty
  always_comb begin
    load_masked = load_row;
    for (int j = COLS; j < tetris_pkg::COLS_DEF; j++) begin
      load_masked[j] = '0;
    end
  end

  //////////////////////////////////////////////////
  // Row registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      // Empty board
      row0 <= '0;
      row1 <= '0;
    end else if (place_en) begin
      // Placement wins over a load in the same cycle
      row0 <= place_row0;
      row1 <= place_row1;
    end else if (load_en) begin
      if (load_sel) begin
        row1 <= load_masked;
      end else begin
        row0 <= load_masked;
      end
    end
  end

endmodule

/* result_port.sv */
`timescale 1ns/1ps

module result_port #(
  parameter int RES_DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   intake_valid,
  input  logic                   place_valid,
  input  tetris_pkg::spawn_res_t place_res,
  input  logic                   ack_out,
  output logic                   buf_space,
  output logic                   req_out,
  output tetris_pkg::spawn_res_t spawn_res,
  output logic                   game_over
);

  localparam int PTR_W = (RES_DEPTH > 1) ? $clog2(RES_DEPTH) : 1;
  localparam int CNT_W = $clog2(RES_DEPTH + 1);

  tetris_pkg::spawn_res_t mem [RES_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] credit;
  logic             push;
  logic             pop;

  // Every placer result is accepted, credits keep room for it
  assign push = place_valid;
  // Result done once the consumer acks
  assign pop  = req_out && ack_out;

  //////////////////////////////////////////////////
  // Credits
  //////////////////////////////////////////////////

  // In flight plus buffered, counted from capture to handshake
  always_ff @(posedge clk) begin
    if (reset) begin
      credit <= '0;
    end else if (intake_valid && !pop) begin
      credit <= credit + 1'b1;
    end else if (!intake_valid && pop) begin
      credit <= credit - 1'b1;
    end
  end

  assign buf_space = (credit < CNT_W'(RES_DEPTH));

  //////////////////////////////////////////////////
  // FIFO
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= place_res;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(RES_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(RES_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (!push && pop) begin
        count <= count - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Four-phase sender
  //////////////////////////////////////////////////

  // Raise once ack is back low and an entry is there or arriving
  // Arriving entry is at the head when the buffer was empty
  always_ff @(posedge clk) begin
    if (reset) begin
      req_out <= 1'b0;
    end else if (req_out) begin
      if (ack_out) begin
        req_out <= 1'b0;
      end
    end else if (!ack_out && (count != '0 || push)) begin
      req_out <= 1'b1;
    end
  end

  // Head entry, held while req_out is up
  assign spawn_res = mem[rd_ptr];

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      game_over <= 1'b0;
    end else if (push && !place_res.ok) begin
      game_over <= 1'b1;
    end
  end

endmodule

/* spawn_top.sv */
`timescale 1ns/1ps

module spawn_top #(
  parameter int COLS      = tetris_pkg::COLS_DEF,
  parameter int ROWS      = tetris_pkg::ROWS_DEF,
  parameter int RES_DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  // Request side
  input  logic                   req_in,
  input  tetris_pkg::spawn_req_t spawn_req,
  output logic                   ack_in,
  // Result side
  output tetris_pkg::spawn_res_t spawn_res,
  output logic                   req_out,
  input  logic                   ack_out,
  // Board load
  input  logic                   load_en,
  input  logic                   load_sel,
  input  tetris_pkg::row_t       load_row,
  // Status
  output tetris_pkg::row_t       top_row0,
  output tetris_pkg::row_t       top_row1,
  output logic                   game_over
);

  logic                   intake_valid;
  tetris_pkg::spawn_req_t intake_req;
  logic                   buf_space;
  logic                   scan_valid;
  tetris_pkg::scan_t      scan_data;
  logic                   place_en;
  tetris_pkg::row_t       place_row0;
  tetris_pkg::row_t       place_row1;
  logic                   place_valid;
  tetris_pkg::spawn_res_t place_res;

  //////////////////////////////////////////////////
  // Pipeline
  //////////////////////////////////////////////////

  spawn_intake u_intake (
    .clk          (clk),
    .reset        (reset),
    .req_in       (req_in),
    .spawn_req    (spawn_req),
    .buf_space    (buf_space),
    .ack_in       (ack_in),
    .intake_valid (intake_valid),
    .intake_req   (intake_req)
  );

  // Reads the store directly, no forwarding needed
  slot_scan #(.COLS(COLS), .ROWS(ROWS)) u_scan (
    .clk          (clk),
    .reset        (reset),
    .intake_valid (intake_valid),
    .intake_req   (intake_req),
    .row0         (top_row0),
    .row1         (top_row1),
    .scan_valid   (scan_valid),
    .scan_data    (scan_data)
  );

  block_placer #(.COLS(COLS), .ROWS(ROWS)) u_placer (
    .clk         (clk),
    .reset       (reset),
    .scan_valid  (scan_valid),
    .scan_data   (scan_data),
    .row0        (top_row0),
    .row1        (top_row1),
    .place_en    (place_en),
    .place_row0  (place_row0),
    .place_row1  (place_row1),
    .place_valid (place_valid),
    .place_res   (place_res)
  );

  // Top two board rows
  top_rows_store #(.COLS(COLS)) u_store (
    .clk        (clk),
    .reset      (reset),
    .place_en   (place_en),
    .place_row0 (place_row0),
    .place_row1 (place_row1),
    .load_en    (load_en),
    .load_sel   (load_sel),
    .load_row   (load_row),
    .row0       (top_row0),
    .row1       (top_row1)
  );

  result_port #(.RES_DEPTH(RES_DEPTH)) u_result (
    .clk          (clk),
    .reset        (reset),
    .intake_valid (intake_valid),
    .place_valid  (place_valid),
    .place_res    (place_res),
    .ack_out      (ack_out),
    .buf_space    (buf_space),
    .req_out      (req_out),
    .spawn_res    (spawn_res),
    .game_over    (game_over)
  );

endmodule

/* spawn_assertions.sv */
`timescale 1ns/1ps

module spawn_assertions (
  input logic                   clk,
  input logic                   reset,
  input logic                   req_in,
  input logic                   ack_in,
  input logic                   req_out,
  input logic                   ack_out,
  input tetris_pkg::spawn_res_t spawn_res,
  input logic                   intake_valid,
  input logic                   scan_valid,
  input logic                   place_valid,
  input logic                   place_en,
  input logic                   game_over
);

  // Failed checks, read back by the testbench
  int fail_count = 0;

  //////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////

  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(ack_in) |-> $past(req_in))
    else begin
      fail_count++;
      $error("ack_in rose without req_in");
    end

  //////////////////////////////////////////////////
  // Result side
  //////////////////////////////////////////////////

  // Held until the consumer answers
  req_out_held: assert property (@(posedge clk) disable iff (reset)
    req_out && !ack_out |=> req_out)
    else begin
      fail_count++;
      $error("req_out dropped before ack_out");
    end

  res_stable: assert property (@(posedge clk) disable iff (reset)
    req_out && $past(req_out) |-> $stable(spawn_res))
    else begin
      fail_count++;
      $error("spawn_res changed while req_out was high");
    end

  // First cycle out of reset
  reset_quiet: assert property (@(posedge clk)
    $fell(reset) |-> !ack_in && !req_out && !intake_valid && !scan_valid &&
                     !place_valid && !place_en && !game_over)
    else begin
      fail_count++;
      $error("control output high right after reset");
    end

endmodule

bind spawn_top spawn_assertions u_assertions (
  .clk          (clk),
  .reset        (reset),
  .req_in       (req_in),
  .ack_in       (ack_in),
  .req_out      (req_out),
  .ack_out      (ack_out),
  .spawn_res    (spawn_res),
  .intake_valid (intake_valid),
  .scan_valid   (scan_valid),
  .place_valid  (place_valid),
  .place_en     (place_en),
  .game_over    (game_over)
);

/* tb_spawn.sv */
`timescale 1ns/1ps

module tb_spawn;

  localparam int COLS        = tetris_pkg::COLS_DEF;
  localparam int ROWS        = tetris_pkg::ROWS_DEF;
  localparam int RES_DEPTH   = 4;
  // Total spawns in all tests
  localparam int N_REQ       = 223;
  localparam int CYCLE_LIMIT = 400 * N_REQ;

  logic                   clk;
  logic                   reset;
  logic                   req_in;
  tetris_pkg::spawn_req_t spawn_req;
  logic                   ack_in;
  tetris_pkg::spawn_res_t spawn_res;
  logic                   req_out;
  logic                   ack_out;
  logic                   load_en;
  logic                   load_sel;
  tetris_pkg::row_t       load_row;
  tetris_pkg::row_t       top_row0;
  tetris_pkg::row_t       top_row1;
  logic                   game_over;

  // Board model and results still owed by the DUT
  tetris_pkg::row_t       m_row0;
  tetris_pkg::row_t       m_row1;
  logic                   exp_game_over;
  tetris_pkg::spawn_res_t exp_q[$];
  // Most recent result taken from the DUT
  tetris_pkg::spawn_res_t last_res = '0;

  int    seed          = 42400;
  int    ack_seed      = 42401;
  int    ack_delay_max = 4;
  int    mismatches    = 0;
  int    other_errors  = 0;
  int    cycles        = 0;
  int    cap_cnt       = 0;
  int    pop_cnt       = 0;
  logic  full_seen     = 1'b0;
  string test_name     = "reset";

  spawn_top #(.COLS(COLS), .ROWS(ROWS), .RES_DEPTH(RES_DEPTH)) dut (
    .clk       (clk),
    .reset     (reset),
    .req_in    (req_in),
    .spawn_req (spawn_req),
    .ack_in    (ack_in),
    .spawn_res (spawn_res),
    .req_out   (req_out),
    .ack_out   (ack_out),
    .load_en   (load_en),
    .load_sel  (load_sel),
    .load_row  (load_row),
    .top_row0  (top_row0),
    .top_row1  (top_row1),
    .game_over (game_over)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Watchdog
  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
    $display("SIMULATION FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Board model
  //////////////////////////////////////////////////

  // Leftmost start column with all piece cells empty or -1
  function automatic int find_col(tetris_pkg::piece_t p);
    int  off;
    logic extra_ok;
    case (p)
      tetris_pkg::TEE: off = 1;
      tetris_pkg::ELL: off = 0;
      tetris_pkg::JAY: off = 2;
      default:         off = -1;
    endcase
    for (int i = 0; i <= COLS - 3; i++) begin
      extra_ok = 1'b1;
      if (off >= 0) begin
        extra_ok = (m_row0[i + off] == 3'd0);
      end
      if (m_row1[i] == 3'd0 && m_row1[i+1] == 3'd0 && m_row1[i+2] == 3'd0 && extra_ok) begin
        return i;
      end
    end
    return -1;
  endfunction

  // Reference column sits left of the piece and wraps at column 0
  function automatic tetris_pkg::spawn_res_t expect_res(int col);
    tetris_pkg::spawn_res_t r;
    r = '0;
    if (col >= 0) begin
      r.ok      = 1'b1;
      r.row_ref = 5'(ROWS - 1);
      r.col_ref = (col == 0) ? 4'(COLS - 1) : 4'(col - 1);
    end
    return r;
  endfunction

  function automatic void paint_piece(tetris_pkg::piece_t p, tetris_pkg::color_t c, int col);
    for (int k = 0; k < 3; k++) begin
      m_row1[col + k] = c;
    end
    case (p)
      tetris_pkg::TEE: m_row0[col + 1] = c;
      tetris_pkg::ELL: m_row0[col] = c;
      tetris_pkg::JAY: m_row0[col + 2] = c;
      default: ;
    endcase
  endfunction

  // Nonzero color
  function automatic tetris_pkg::color_t rand_color();
    int r;
    r = $random(seed);
    return (r[2:0] == 3'd0) ? 3'd1 : r[2:0];
  endfunction

  // Each cell filled with chance dens/16
  function automatic tetris_pkg::row_t rand_row(int dens);
    tetris_pkg::row_t rw;
    int               r;
    rw = '0;
    for (int j = 0; j < COLS; j++) begin
      r = $random(seed);
      if (int'(r[3:0]) < dens) begin
        rw[j] = (r[6:4] == 3'd0) ? 3'd7 : r[6:4];
      end
    end
    return rw;
  endfunction

  //////////////////////////////////////////////////
  // Checks and drivers
  //////////////////////////////////////////////////

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] got);
    assert (exp == got) else begin
      mismatches++;
      $display("MISMATCH %s expected %0h actual %0h", name, exp, got);
    end
  endtask

  task automatic check_rows();
    check_val({test_name, "_row0"}, 32'(m_row0), 32'(top_row0));
    check_val({test_name, "_row1"}, 32'(m_row1), 32'(top_row1));
    check_val({test_name, "_game_over"}, 32'(exp_game_over), 32'(game_over));
  endtask

  // Model update and then one four-phase request
  task automatic spawn(tetris_pkg::piece_t p, tetris_pkg::color_t c);
    int col;
    col = find_col(p);
    exp_q.push_back(expect_res(col));
    if (col >= 0) begin
      paint_piece(p, c, col);
    end else begin
      exp_game_over = 1'b1;
    end
    spawn_req.piece = p;
    spawn_req.color = c;
    req_in = 1'b1;
    while (!ack_in) @(negedge clk);
    req_in = 1'b0;
    while (ack_in) @(negedge clk);
  endtask

  // All results delivered means every placement is in the store
  task automatic wait_idle();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  task automatic load_board_row(logic sel, tetris_pkg::row_t rw);
    wait_idle();
    check_rows();
    load_en  = 1'b1;
    load_sel = sel;
    load_row = rw;
    @(negedge clk);
    load_en = 1'b0;
    if (sel) begin
      m_row1 = rw;
    end else begin
      m_row0 = rw;
    end
  endtask

  //////////////////////////////////////////////////
  // Result consumer and buffer monitor
  //////////////////////////////////////////////////

  initial begin
    int   delay;
    int   r;
    logic ack_prev;
    logic pend_pop;
    ack_out  = 1'b0;
    delay    = 0;
    ack_prev = 1'b0;
    pend_pop = 1'b0;
    forever begin
      @(negedge clk);
      if (!reset) begin
        // A new capture needs a free credit
        if (ack_in && !ack_prev) begin
          assert (cap_cnt - pop_cnt < RES_DEPTH) else begin
            other_errors++;
            $display("ERROR: ack_in rose while the result buffer was full");
          end
          cap_cnt++;
        end
        if (pend_pop) begin
          pop_cnt++;
        end
        if (cap_cnt - pop_cnt == RES_DEPTH) begin
          full_seen = 1'b1;
        end
        ack_prev = ack_in;
        // Four-phase return with random delay
        if (ack_out) begin
          if (!req_out) begin
            ack_out = 1'b0;
            r       = $random(ack_seed);
            delay   = (r & 32'h7fff_ffff) % ack_delay_max;
          end
        end else if (req_out) begin
          if (delay > 0) begin
            delay--;
          end else begin
            assert (exp_q.size() != 0) else begin
              other_errors++;
              $display("ERROR: result arrived with no request pending");
            end
            last_res = spawn_res;
            if (exp_q.size() != 0) begin
              check_val({test_name, "_result"}, 32'(exp_q.pop_front()), 32'(spawn_res));
            end
            ack_out = 1'b1;
          end
        end
        pend_pop = req_out && ack_out;
      end
    end
  end

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    tetris_pkg::spawn_res_t want_res;
    tetris_pkg::row_t       want;
    tetris_pkg::piece_t     p;
    int                     r;
    reset         = 1'b1;
    req_in        = 1'b0;
    spawn_req     = '0;
    load_en       = 1'b0;
    load_sel      = 1'b0;
    load_row      = '0;
    m_row0        = '0;
    m_row1        = '0;
    exp_game_over = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // TEE on the empty board wraps its reference column
    test_name = "empty_tee";
    want_res  = '{ok: 1'b1, row_ref: 5'd21, col_ref: 4'd9};
    spawn(tetris_pkg::TEE, 3'd5);
    wait_idle();
    check_val("empty_tee_result", 32'(want_res), 32'(last_res));
    check_rows();
    want = '0;
    for (int j = 0; j < 3; j++) begin
      want[j] = 3'd5;
    end
    check_val("empty_tee_top_row1", 32'(want), 32'(top_row1));
    want    = '0;
    want[1] = 3'd5;
    check_val("empty_tee_top_row0", 32'(want), 32'(top_row0));

    // Every kind on random boards
    test_name = "random_fill";
    for (int round = 0; round < 2; round++) begin
      load_board_row(1'b0, rand_row(6));
      load_board_row(1'b1, rand_row(4));
      for (int k = 0; k < 4; k++) begin
        spawn(tetris_pkg::piece_t'(2'(k)), rand_color());
      end
    end
    wait_idle();
    check_rows();

    // No place on a full row 1 and game over stays set
    test_name = "full_row";
    load_board_row(1'b0, rand_row(8));
    load_board_row(1'b1, rand_row(16));
    r = $random(seed);
    p = tetris_pkg::piece_t'(r[1:0]);
    spawn(p, rand_color());
    wait_idle();
    check_val("full_row_result", 32'd0, 32'(last_res));
    check_rows();
    load_board_row(1'b0, '0);
    load_board_row(1'b1, '0);
    spawn(tetris_pkg::BAR, rand_color());
    wait_idle();
    check_rows();
    check_val("full_row_sticky", 32'd1, 32'(game_over));

    // Slow consumer fills the buffer
    test_name     = "backpressure";
    load_board_row(1'b0, '0);
    load_board_row(1'b1, '0);
    ack_delay_max = 40;
    full_seen     = 1'b0;
    repeat (12) begin
      r = $random(seed);
      spawn(tetris_pkg::piece_t'(r[1:0]), rand_color());
    end
    wait_idle();
    ack_delay_max = 4;
    check_rows();
    assert (full_seen) else begin
      other_errors++;
      $display("ERROR: result buffer never filled under back-pressure");
    end

    // Loads and spawns mixed
    test_name = "random_mix";
    repeat (200) begin
      r = $random(seed);
      if (r[1:0] == 2'd0) begin
        load_board_row(r[2], rand_row(4));
      end
      spawn(tetris_pkg::piece_t'(r[9:8]), rand_color());
    end
    wait_idle();
    check_rows();

    $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
             mismatches, other_errors, dut.u_assertions.fail_count);
    if (mismatches + other_errors + dut.u_assertions.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
tetris_pkg.sv
spawn_intake.sv
slot_scan.sv
block_placer.sv
top_rows_store.sv
result_port.sv
spawn_top.sv
spawn_assertions.sv
tb_spawn.sv

/* Makefile */
# Verilator build and run for the spawn pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_spawn
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
